//--- Makefile
# Verilator build of the execute stage testbench

VERILATOR ?= verilator
TOP       ?= exu_tb
FILELIST  ?= exu_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SOURCES   := $(wildcard source/*.sv dv/*.sv include/*.svh)
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

//--- dv/exu_clock_gen.sv
module exu_clock_gen #(
  parameter int PERIOD       = 100,
  parameter int RESET_CYCLES = 2
) (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #(PERIOD / 2) clock = ~clock;
  end

  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    #10 reset = 1'b0; // released with the stimulus
  end

endmodule

//--- dv/exu_tb.sv
`include "exu_defines.svh"

module exu_tb;
  import exu_pkg::*;

  localparam int NUM_INST = 400;

  typedef struct packed {
    wb_t                  wb;
    logic                 flush;
    logic [`EXU_XLEN-1:0] dnpc;
  } expect_t;

  logic clock, reset, in_valid, in_ready, in_alu_src, in_alu_alt, in_rd_src;
  logic [`EXU_XLEN-1:0] in_pc, in_val_a, in_val_b, in_val_c;
  logic [2:0] in_alu_op, in_goto;
  logic [4:0] in_rd;
  logic [3:0] in_ls;
  logic [1:0] in_csrw;
  logic out_valid, out_ready, out_gpr_wen, out_csr_wen, jump_flush;
  logic [4:0] out_gpr_waddr;
  logic [11:0] out_csr_waddr;
  logic [`EXU_XLEN-1:0] out_gpr_wdata, out_csr_wdata, jump_dnpc;
  logic mem_arvalid, mem_arready, mem_rvalid, mem_rready, mem_awvalid, mem_awready;
  logic mem_wvalid, mem_wready, mem_bvalid, mem_bready;
  logic [`EXU_XLEN-1:0] mem_araddr, mem_awaddr;
  logic [2:0] mem_arsize, mem_awsize;
  logic [`EXU_BUS_WIDTH-1:0] mem_rdata, mem_wdata;
  logic [`EXU_STRB_WIDTH-1:0] mem_wstrb;

  exu_clock_gen u_clock_gen (.clock(clock), .reset(reset));

  exu_top UUT (.*);

  logic [31:0] lfsr;
  logic [63:0] bus_mem [64]; // what the responder holds
  logic [63:0] ref_mem [64]; // expected contents
  expect_t     sb [$];
  expect_t     snap;
  int          presented, retired, cycles, stall_left, rd_wait, b_wait;
  logic        held, accepted, r_fire, b_fire, rd_pend, b_pend, aw_got, w_got;
  logic [31:0] rd_addr, aw_addr, exp_addr;
  logic [2:0]  exp_size;
  logic [63:0] w_data, exp_data;
  logic [7:0]  w_strb, exp_strb;

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]; // taps 32 22 2 1
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic logic [63:0] fill_word(input int i);
    return {32'(i) * 32'h9e37_79b1, 32'(i) ^ 32'ha5c3_0f00};
  endfunction

  function automatic logic [63:0] byte_mask(input logic [7:0] strb);
    logic [63:0] m;
    for (int i = 0; i < 8; i++) m[i*8 +: 8] = {8{strb[i]}};
    return m;
  endfunction

  task automatic report_error(input string msg);
    $display("[ERROR] %0t %s", $time, msg);
    $display("ERRORS FOUND");
    $fatal(1, "check failed");
  endtask

  task automatic gen_inst();
    logic [2:0] off;
    logic [5:0] widx;
    logic [1:0] size;
    in_pc      = rand_bits(32);
    in_val_a   = rand_bits(32);
    in_val_b   = rand_bits(32);
    in_val_c   = rand_bits(32);
    in_alu_src = 1'(rand_bits(1));
    in_alu_op  = 3'(rand_bits(3));
    in_alu_alt = 1'(rand_bits(1));
    in_rd      = (rand_bits(3) == 0) ? 5'd0 : 5'(rand_bits(5));
    in_rd_src  = 1'(rand_bits(1));
    in_goto    = 3'(rand_bits(3) % 6);
    in_ls      = 4'd0;
    in_csrw    = 2'(rand_bits(2));
    if (rand_bits(2) == 0) begin
      size = 2'(rand_bits(2) % 3);
      off  = 3'(rand_bits(3));
      if (size == 2'd1) off[0] = 1'b0; // keep the access inside one bus word
      if (size == 2'd2) off[1:0] = 2'b00;
      widx       = 6'(rand_bits(6));
      in_val_b   = 32'(rand_bits(4));
      in_val_a   = {23'd0, widx, off} - in_val_b;
      in_alu_src = 1'b0;
      in_alu_op  = 3'd0;
      in_alu_alt = 1'b0;
      in_rd_src  = 1'b0;
      in_goto    = 3'd0;
      in_csrw    = 2'd0;
      in_ls      = (rand_bits(1) != 0) ? {1'b1, 1'(rand_bits(1)), size} : {2'b01, size};
    end
  endtask

  // expected result of the instruction accepted at the coming edge
  task automatic predict();
    logic [31:0] a, res, ld, base, offs;
    logic [4:0]  sh;
    logic [63:0] word;
    logic [5:0]  idx;
    logic [2:0]  off;
    expect_t     e;
    int          nbytes;
    a  = in_alu_src ? in_pc : in_val_a;
    sh = in_val_b[4:0];
    case (in_alu_op)
      3'd0:    res = in_alu_alt ? a - in_val_b : a + in_val_b;
      3'd1:    res = a << sh;
      3'd2:    res = {31'b0, (a[31] != in_val_b[31]) ? a[31] : (a < in_val_b)};
      3'd3:    res = {31'b0, a < in_val_b};
      3'd4:    res = a ^ in_val_b;
      3'd5:    res = (a >> sh) | ((in_alu_alt && a[31]) ? ~(32'hffff_ffff >> sh) : 32'h0);
      3'd6:    res = a | in_val_b;
      default: res = a & in_val_b;
    endcase
    idx    = res[8:3];
    off    = res[2:0];
    nbytes = 1 << in_ls[1:0];
    word   = ref_mem[idx] >> {off, 3'b000};
    ld     = word[31:0];
    if (in_ls[1:0] == 2'd0) ld = {{24{in_ls[2] & ld[7]}}, ld[7:0]};
    else if (in_ls[1:0] == 2'd1) ld = {{16{in_ls[2] & ld[15]}}, ld[15:0]};
    e.wb.gpr_wen   = in_rd != 5'd0;
    e.wb.gpr_waddr = in_rd;
    e.wb.gpr_wdata = in_ls[3] ? ld : (in_rd_src ? in_val_a : res);
    e.wb.csr_wen   = in_csrw != 2'd0;
    e.wb.csr_waddr = (in_csrw == 2'd3) ? 12'h000 : in_val_c[11:0];
    e.wb.csr_wdata = in_csrw[1] ? in_val_b : res;
    case (in_goto)
      3'd0:    e.flush = 1'b0;
      3'd4:    e.flush = res != 32'd0;
      3'd5:    e.flush = res == 32'd0;
      default: e.flush = 1'b1;
    endcase
    base     = (in_goto == 3'd2 || in_goto == 3'd3) ? in_val_a : in_pc;
    offs     = (in_goto == 3'd3) ? 32'd0 : in_val_c;
    e.dnpc   = (base + offs) & ~32'h1;
    exp_addr = res;
    exp_size = 3'($clog2(nbytes)); // bus size is log2 of the byte count
    if (in_ls != 4'd0 && !in_ls[3]) begin
      exp_strb = '0;
      exp_data = '0;
      for (int i = 0; i < nbytes; i++) begin
        exp_strb[off + i]              = 1'b1;
        exp_data[(off + i) * 8 +: 8]   = in_val_c[i*8 +: 8];
        ref_mem[idx][(off + i) * 8 +: 8] = in_val_c[i*8 +: 8];
      end
    end
    sb.push_back(e);
  endtask

  // sampled mid-cycle, describes the edge to come
  task automatic check_cycle();
    expect_t got;
    expect_t want;
    got = {out_gpr_wen, out_gpr_waddr, out_gpr_wdata, out_csr_wen, out_csr_waddr,
           out_csr_wdata, jump_flush, jump_dnpc};
    if (in_valid && in_ready) begin
      predict();
      accepted = 1'b1;
    end
    if (held) begin
      assert (out_valid && got == snap) else report_error("output changed while stalled");
    end
    held = out_valid && !out_ready;
    snap = got;
    if (held) assert (!in_ready) else report_error("in_ready high while output stalled");
    assert (out_valid || !jump_flush) else report_error("jump_flush without out_valid");
    if (out_valid && out_ready) begin
      if (sb.size() == 0) begin
        report_error("writeback with no instruction pending");
      end else begin
        want = sb.pop_front();
        assert (got == want)
          else report_error($sformatf("writeback %h, expected %h", got, want));
        retired++;
      end
    end
    if (mem_arvalid && mem_arready) begin
      assert (mem_araddr == exp_addr && mem_arsize == exp_size)
        else report_error($sformatf("araddr %h arsize %0d", mem_araddr, mem_arsize));
      rd_pend = 1'b1;
      rd_addr = mem_araddr;
      rd_wait = rand_bits(2);
    end
    if (mem_rvalid && mem_rready) r_fire = 1'b1;
    if (mem_awvalid && mem_awready) begin
      assert (mem_awaddr == exp_addr && mem_awsize == exp_size)
        else report_error($sformatf("awaddr %h awsize %0d", mem_awaddr, mem_awsize));
      aw_got  = 1'b1;
      aw_addr = mem_awaddr;
    end
    if (mem_wvalid && mem_wready) begin
      assert (mem_wstrb == exp_strb && (mem_wdata & byte_mask(exp_strb)) == exp_data)
        else report_error($sformatf("write strb %h data %h", mem_wstrb, mem_wdata));
      w_got  = 1'b1;
      w_data = mem_wdata;
      w_strb = mem_wstrb;
    end
    if (mem_bvalid && mem_bready) b_fire = 1'b1;
  endtask

  task automatic drive_cycle();
    mem_arready = 1'(rand_bits(1));
    mem_awready = 1'(rand_bits(1));
    mem_wready  = 1'(rand_bits(1));
    if (r_fire) begin
      mem_rvalid = 1'b0;
      r_fire     = 1'b0;
    end
    if (rd_pend) begin
      if (rd_wait == 0) begin
        mem_rvalid = 1'b1;
        mem_rdata  = bus_mem[rd_addr[8:3]];
        rd_pend    = 1'b0;
      end else rd_wait--;
    end
    if (b_fire) begin
      mem_bvalid = 1'b0;
      b_fire     = 1'b0;
    end
    if (aw_got && w_got) begin
      for (int i = 0; i < 8; i++)
        if (w_strb[i]) bus_mem[aw_addr[8:3]][i*8 +: 8] = w_data[i*8 +: 8];
      aw_got = 1'b0;
      w_got  = 1'b0;
      b_pend = 1'b1;
      b_wait = rand_bits(2);
    end
    if (b_pend) begin
      if (b_wait == 0) begin
        mem_bvalid = 1'b1;
        b_pend     = 1'b0;
      end else b_wait--;
    end
    if (stall_left > 0) begin
      stall_left--;
      out_ready = 1'b0;
    end else if (rand_bits(4) == 0) begin
      stall_left = rand_bits(3); // a longer back-pressure stretch
      out_ready  = 1'b0;
    end else out_ready = (rand_bits(2) != 0);
    if (accepted || !in_valid) begin
      accepted = 1'b0;
      if (presented < NUM_INST && rand_bits(2) != 0) begin
        gen_inst();
        in_valid = 1'b1;
        presented++;
      end else in_valid = 1'b0;
    end
  endtask

  always @(posedge clock) begin
    cycles++;
    if (cycles == `EXU_TB_TIMEOUT) begin
      $display("timeout after %0d cycles with %0d instructions retired", cycles, retired);
      $display("ERRORS FOUND");
      $fatal(1, "timeout");
    end
  end

  initial begin
    lfsr = 32'hfcdd;
    {in_valid, in_pc, in_val_a, in_val_b, in_val_c, in_alu_src, in_alu_op} = '0;
    {in_alu_alt, in_rd, in_rd_src, in_ls, in_goto, in_csrw, out_ready} = '0;
    {mem_arready, mem_rvalid, mem_rdata, mem_awready, mem_wready, mem_bvalid} = '0;
    {held, accepted, r_fire, b_fire, rd_pend, b_pend, aw_got, w_got} = '0;
    {presented, retired, cycles, stall_left, rd_wait, b_wait} = '0;
    {rd_addr, aw_addr, exp_addr, exp_size, w_data, exp_data, w_strb, exp_strb} = '0;
    snap = '0;
    for (int i = 0; i < 64; i++) begin
      bus_mem[i] = fill_word(i);
      ref_mem[i] = fill_word(i);
    end
    @(negedge reset);
    while (retired < NUM_INST) begin
      @(negedge clock);
      check_cycle();
      @(posedge clock);
      #10;
      drive_cycle();
    end
    $display("NO ERRORS");
    $finish;
  end

endmodule

//--- exu_top.f
+incdir+include
source/exu_pkg.sv
source/exu_mem_if.sv
source/exu_lsu_if.sv
source/exu_alu.sv
source/exu_branch.sv
source/exu_lsu.sv
source/exu_stage.sv
source/exu_top.sv
dv/exu_clock_gen.sv
dv/exu_tb.sv

//--- include/exu_defines.svh
`ifndef EXU_DEFINES_SVH
`define EXU_DEFINES_SVH

// data path width of the core
`define EXU_XLEN 32

// memory side
`define EXU_BUS_WIDTH 64
`define EXU_STRB_WIDTH 8

// watchdog for about 400 instructions of up to 20 cycles each
`define EXU_TB_TIMEOUT 8000

`endif

//--- source/exu_alu.sv
`include "exu_defines.svh"

module exu_alu (
  input  logic [`EXU_XLEN-1:0] a,
  input  logic [`EXU_XLEN-1:0] b,
  input  exu_pkg::alu_op_t     op,
  input  logic                 alt,
  output logic [`EXU_XLEN-1:0] result
);
  import exu_pkg::*;

  logic [4:0]           shamt;
  logic                 lt_s;
  logic                 lt_u;
  logic [`EXU_XLEN-1:0] sra;

  assign shamt = b[4:0];
  assign lt_s  = $signed(a) < $signed(b);
  assign lt_u  = a < b;
  assign sra   = $unsigned($signed(a) >>> shamt); // arithmetic shift keeps the sign

  always_comb begin
    case (op)
      ALU_ADD:  result = alt ? a - b : a + b;
      ALU_SLL:  result = a << shamt;
      ALU_SLT:  result = {{(`EXU_XLEN-1){1'b0}}, lt_s};
      ALU_SLTU: result = {{(`EXU_XLEN-1){1'b0}}, lt_u};
      ALU_XOR:  result = a ^ b;
      ALU_SRL:  result = alt ? sra : a >> shamt;
      ALU_OR:   result = a | b;
      ALU_AND:  result = a & b;
      default:  result = '0;
    endcase
  end

  always_comb begin
    assert (!$isunknown(op)) else $error("alu op unknown");
  end

endmodule

//--- source/exu_branch.sv
`include "exu_defines.svh"

module exu_branch (
  input  exu_pkg::goto_t       goto,
  input  logic [`EXU_XLEN-1:0] pc,
  input  logic [`EXU_XLEN-1:0] val_a,
  input  logic [`EXU_XLEN-1:0] val_c,
  input  logic [`EXU_XLEN-1:0] alu_result,
  output logic                 taken,
  output logic [`EXU_XLEN-1:0] target
);
  import exu_pkg::*;

  logic                 nonzero;
  logic [`EXU_XLEN-1:0] base;
  logic [`EXU_XLEN-1:0] offset;
  logic [`EXU_XLEN-1:0] sum;

  assign nonzero = |alu_result;

  always_comb begin
    case (goto)
      GOTO_NONE: taken = 1'b0;
      GOTO_BNZ:  taken = nonzero;
      GOTO_BZ:   taken = ~nonzero;
      default:   taken = 1'b1; // jal, jalr, trap return
    endcase
  end

  assign base   = (goto == GOTO_JALR || goto == GOTO_RET) ? val_a : pc;
  assign offset = (goto == GOTO_RET) ? '0 : val_c;
  assign sum    = base + offset;
  assign target = {sum[`EXU_XLEN-1:1], 1'b0};

endmodule

//--- source/exu_lsu.sv
`include "exu_defines.svh"

module exu_lsu (
  input logic       clock,
  input logic       reset,
  exu_lsu_if.lsu    req,
  exu_mem_if.master mem
);
  import exu_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOAD_REQ,
    ST_LOAD_RESP,
    ST_STORE_REQ,
    ST_STORE_ADDR, // data taken, address pending
    ST_STORE_DATA, // address taken, data pending
    ST_STORE_RESP
  } state_t;

  state_t                     state;
  state_t                     state_next;
  ls_t                        ls_q;
  logic [`EXU_XLEN-1:0]       addr_q;
  logic [`EXU_XLEN-1:0]       wdata_q;
  logic [`EXU_XLEN-1:0]       rdata_q;
  logic                       done_q;
  logic                       load_fire;
  logic                       store_fire;
  logic [5:0]                 bit_shift;
  logic [`EXU_BUS_WIDTH-1:0]  rdata_shift;
  logic [`EXU_XLEN-1:0]       load_ext;
  logic [`EXU_STRB_WIDTH-1:0] strb_base;

  assign load_fire  = (state == ST_LOAD_RESP) && mem.rvalid;
  assign store_fire = (state == ST_STORE_RESP) && mem.bvalid;

  always_ff @(posedge clock) begin
    if (reset) begin
      state  <= ST_IDLE;
      done_q <= 1'b0;
    end else begin
      state  <= state_next;
      done_q <= load_fire || store_fire;
    end
  end

  always_ff @(posedge clock) begin
    if (req.start) begin
      ls_q    <= req.ls;
      addr_q  <= req.addr;
      wdata_q <= req.wdata;
    end
    if (load_fire) rdata_q <= load_ext;
  end

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE:       if (req.start) state_next = req.ls[3] ? ST_LOAD_REQ : ST_STORE_REQ;
      ST_LOAD_REQ:   if (mem.arready) state_next = ST_LOAD_RESP;
      ST_LOAD_RESP:  if (mem.rvalid) state_next = ST_IDLE;
      ST_STORE_REQ: begin
        if (mem.awready && mem.wready) state_next = ST_STORE_RESP;
        else if (mem.awready) state_next = ST_STORE_DATA;
        else if (mem.wready) state_next = ST_STORE_ADDR;
      end
      ST_STORE_ADDR: if (mem.awready) state_next = ST_STORE_RESP;
      ST_STORE_DATA: if (mem.wready) state_next = ST_STORE_RESP;
      ST_STORE_RESP: if (mem.bvalid) state_next = ST_IDLE;
      default:       state_next = ST_IDLE;
    endcase
  end

  assign bit_shift = {addr_q[2:0], 3'b000};

  // align then extend the load data
  assign rdata_shift = mem.rdata >> bit_shift;
  always_comb begin
    case (ls_q[1:0])
      LS_BYTE: load_ext = {{(`EXU_XLEN-8){rdata_shift[7] & ls_q[2]}}, rdata_shift[7:0]};
      LS_HALF: load_ext = {{(`EXU_XLEN-16){rdata_shift[15] & ls_q[2]}}, rdata_shift[15:0]};
      default: load_ext = rdata_shift[`EXU_XLEN-1:0];
    endcase
  end

  always_comb begin
    case (ls_q[1:0])
      LS_BYTE: strb_base = `EXU_STRB_WIDTH'(4'b0001);
      LS_HALF: strb_base = `EXU_STRB_WIDTH'(4'b0011);
      LS_WORD: strb_base = `EXU_STRB_WIDTH'(4'b1111);
      default: strb_base = '0;
    endcase
  end

  assign mem.arvalid = state == ST_LOAD_REQ;
  assign mem.araddr  = addr_q;
  assign mem.arsize  = {1'b0, ls_q[1:0]};
  assign mem.rready  = state == ST_LOAD_RESP;

  assign mem.awvalid = (state == ST_STORE_REQ) || (state == ST_STORE_ADDR);
  assign mem.awaddr  = addr_q;
  assign mem.awsize  = {1'b0, ls_q[1:0]};
  assign mem.wvalid  = (state == ST_STORE_REQ) || (state == ST_STORE_DATA);
  assign mem.wdata   = {{(`EXU_BUS_WIDTH-`EXU_XLEN){1'b0}}, wdata_q} << bit_shift;
  assign mem.wstrb   = strb_base << addr_q[2:0];
  assign mem.bready  = state == ST_STORE_RESP;

  assign req.done  = done_q;
  assign req.rdata = rdata_q;

  // one access at a time
  a_start_idle: assert property (@(posedge clock) disable iff (reset)
    req.start |-> state == ST_IDLE);

  a_ar_hold: assert property (@(posedge clock) disable iff (reset)
    mem.arvalid && !mem.arready |=> mem.arvalid);

endmodule

//--- source/exu_lsu_if.sv
`include "exu_defines.svh"

interface exu_lsu_if;
  import exu_pkg::*;

  logic                 start; // one cycle
  ls_t                  ls;
  logic [`EXU_XLEN-1:0] addr;
  logic [`EXU_XLEN-1:0] wdata;
  logic                 done;  // one cycle
  logic [`EXU_XLEN-1:0] rdata; // already extended

  modport stage (
    output start, ls, addr, wdata,
    input  done, rdata
  );

  modport lsu (
    input  start, ls, addr, wdata,
    output done, rdata
  );

endinterface

//--- source/exu_mem_if.sv
`include "exu_defines.svh"

interface exu_mem_if;

  // read channel
  logic                       arvalid;
  logic                       arready;
  logic [`EXU_XLEN-1:0]       araddr;
  logic [2:0]                 arsize;
  logic                       rvalid;
  logic                       rready;
  logic [`EXU_BUS_WIDTH-1:0]  rdata;

  // write channel
  logic                       awvalid;
  logic                       awready;
  logic [`EXU_XLEN-1:0]       awaddr;
  logic [2:0]                 awsize;
  logic                       wvalid;
  logic                       wready;
  logic [`EXU_BUS_WIDTH-1:0]  wdata;
  logic [`EXU_STRB_WIDTH-1:0] wstrb;
  logic                       bvalid;
  logic                       bready;

  modport master (
    output arvalid, araddr, arsize, rready,
    output awvalid, awaddr, awsize, wvalid, wdata, wstrb, bready,
    input  arready, rvalid, rdata, awready, wready, bvalid
  );

  modport slave (
    input  arvalid, araddr, arsize, rready,
    input  awvalid, awaddr, awsize, wvalid, wdata, wstrb, bready,
    output arready, rvalid, rdata, awready, wready, bvalid
  );

endinterface

//--- source/exu_pkg.sv
`include "exu_defines.svh"

package exu_pkg;

  typedef enum logic [2:0] {
    ALU_ADD  = 3'b000,
    ALU_SLL  = 3'b001,
    ALU_SLT  = 3'b010,
    ALU_SLTU = 3'b011,
    ALU_XOR  = 3'b100,
    ALU_SRL  = 3'b101,
    ALU_OR   = 3'b110,
    ALU_AND  = 3'b111
  } alu_op_t;

  // [3] load, [2] signed, [1:0] size; zero means no memory access
  typedef logic [3:0] ls_t;

  localparam logic [1:0] LS_BYTE = 2'b00;
  localparam logic [1:0] LS_HALF = 2'b01;
  localparam logic [1:0] LS_WORD = 2'b10;

  typedef enum logic [2:0] {
    GOTO_NONE = 3'b000,
    GOTO_JAL  = 3'b001,
    GOTO_JALR = 3'b010,
    GOTO_RET  = 3'b011, // trap return
    GOTO_BNZ  = 3'b100,
    GOTO_BZ   = 3'b101
  } goto_t;

  typedef struct packed {
    logic [`EXU_XLEN-1:0] pc;
    logic [`EXU_XLEN-1:0] val_a;
    logic [`EXU_XLEN-1:0] val_b;
    logic [`EXU_XLEN-1:0] val_c;
    logic                 alu_src; // pc as first operand
    alu_op_t              alu_op;
    logic                 alu_alt;
    logic [4:0]           rd;
    logic                 rd_src;
    ls_t                  ls;
    goto_t                goto;
    logic [1:0]           csrw;
  } exu_in_t;

  typedef struct packed {
    logic                 gpr_wen;
    logic [4:0]           gpr_waddr;
    logic [`EXU_XLEN-1:0] gpr_wdata;
    logic                 csr_wen;
    logic [11:0]          csr_waddr;
    logic [`EXU_XLEN-1:0] csr_wdata;
  } wb_t;

endpackage

//--- source/exu_stage.sv
`include "exu_defines.svh"

module exu_stage (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 in_valid,
  output logic                 in_ready,
  input  exu_pkg::exu_in_t     in_data,
  input  logic                 out_ready,
  output logic                 out_valid,
  output exu_pkg::wb_t         out_data,
  output logic                 jump_flush,
  output logic [`EXU_XLEN-1:0] jump_dnpc,
  exu_mem_if.master            mem
);
  import exu_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ISSUE, // start strobe to lsu
    ST_WAIT,
    ST_HOLD
  } state_t;

  state_t               state;
  state_t               state_next;
  exu_in_t              ex;
  logic                 accept;
  logic [`EXU_XLEN-1:0] alu_a;
  logic [`EXU_XLEN-1:0] alu_result;
  logic                 taken;

  exu_lsu_if lsu ();

  assign accept   = in_valid && in_ready;
  assign in_ready = (state == ST_IDLE) || (state == ST_HOLD && out_ready);

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= ST_IDLE;
      ex    <= '0;
    end else begin
      state <= state_next;
      if (accept) ex <= in_data;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      ST_ISSUE: state_next = ST_WAIT;
      ST_WAIT:  if (lsu.done) state_next = ST_HOLD;
      ST_HOLD:  if (out_ready) state_next = ST_IDLE;
      default:  ;
    endcase
    if (accept) state_next = (|in_data.ls) ? ST_ISSUE : ST_HOLD;
  end

  assign alu_a = ex.alu_src ? ex.pc : ex.val_a;

  exu_alu u_alu (
    .a      (alu_a),
    .b      (ex.val_b),
    .op     (ex.alu_op),
    .alt    (ex.alu_alt),
    .result (alu_result)
  );

  exu_branch u_branch (
    .goto       (ex.goto),
    .pc         (ex.pc),
    .val_a      (ex.val_a),
    .val_c      (ex.val_c),
    .alu_result (alu_result),
    .taken      (taken),
    .target     (jump_dnpc)
  );

  assign lsu.start = state == ST_ISSUE;
  assign lsu.ls    = ex.ls;
  assign lsu.addr  = alu_result;
  assign lsu.wdata = ex.val_c;

  exu_lsu u_lsu (
    .clock (clock),
    .reset (reset),
    .req   (lsu.lsu),
    .mem   (mem)
  );

  assign out_valid  = state == ST_HOLD;
  assign jump_flush = taken && out_valid; // not-taken assumed upstream

  // lsu rdata holds until the next load ends
  assign out_data.gpr_wen   = |ex.rd;
  assign out_data.gpr_waddr = ex.rd;
  assign out_data.gpr_wdata = ex.ls[3] ? lsu.rdata : (ex.rd_src ? ex.val_a : alu_result);
  assign out_data.csr_wen   = |ex.csrw;
  assign out_data.csr_waddr = (&ex.csrw) ? 12'h000 : ex.val_c[11:0]; // ebreak -> csr 0
  assign out_data.csr_wdata = ex.csrw[1] ? ex.val_b : alu_result;

  a_out_hold: assert property (@(posedge clock) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

//--- source/exu_top.sv
`include "exu_defines.svh"

module exu_top (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       in_valid,
  output logic                       in_ready,
  input  logic [`EXU_XLEN-1:0]       in_pc,
  input  logic [`EXU_XLEN-1:0]       in_val_a,
  input  logic [`EXU_XLEN-1:0]       in_val_b,
  input  logic [`EXU_XLEN-1:0]       in_val_c,
  input  logic                       in_alu_src,
  input  logic [2:0]                 in_alu_op,
  input  logic                       in_alu_alt,
  input  logic [4:0]                 in_rd,
  input  logic                       in_rd_src,
  input  logic [3:0]                 in_ls,
  input  logic [2:0]                 in_goto,
  input  logic [1:0]                 in_csrw,
  output logic                       out_valid,
  input  logic                       out_ready,
  output logic                       out_gpr_wen,
  output logic [4:0]                 out_gpr_waddr,
  output logic [`EXU_XLEN-1:0]       out_gpr_wdata,
  output logic                       out_csr_wen,
  output logic [11:0]                out_csr_waddr,
  output logic [`EXU_XLEN-1:0]       out_csr_wdata,
  output logic                       jump_flush,
  output logic [`EXU_XLEN-1:0]       jump_dnpc,
  output logic                       mem_arvalid,
  input  logic                       mem_arready,
  output logic [`EXU_XLEN-1:0]       mem_araddr,
  output logic [2:0]                 mem_arsize,
  input  logic                       mem_rvalid,
  output logic                       mem_rready,
  input  logic [`EXU_BUS_WIDTH-1:0]  mem_rdata,
  output logic                       mem_awvalid,
  input  logic                       mem_awready,
  output logic [`EXU_XLEN-1:0]       mem_awaddr,
  output logic [2:0]                 mem_awsize,
  output logic                       mem_wvalid,
  input  logic                       mem_wready,
  output logic [`EXU_BUS_WIDTH-1:0]  mem_wdata,
  output logic [`EXU_STRB_WIDTH-1:0] mem_wstrb,
  input  logic                       mem_bvalid,
  output logic                       mem_bready
);
  import exu_pkg::*;

  exu_in_t in_data;
  wb_t     out_data;

  exu_mem_if mem ();

  assign in_data.pc      = in_pc;
  assign in_data.val_a   = in_val_a;
  assign in_data.val_b   = in_val_b;
  assign in_data.val_c   = in_val_c;
  assign in_data.alu_src = in_alu_src;
  assign in_data.alu_op  = alu_op_t'(in_alu_op);
  assign in_data.alu_alt = in_alu_alt;
  assign in_data.rd      = in_rd;
  assign in_data.rd_src  = in_rd_src;
  assign in_data.ls      = in_ls;
  assign in_data.goto    = goto_t'(in_goto);
  assign in_data.csrw    = in_csrw;

  exu_stage u_stage (
    .clock      (clock),
    .reset      (reset),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_data    (in_data),
    .out_ready  (out_ready),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .jump_flush (jump_flush),
    .jump_dnpc  (jump_dnpc),
    .mem        (mem.master)
  );

  assign out_gpr_wen   = out_data.gpr_wen;
  assign out_gpr_waddr = out_data.gpr_waddr;
  assign out_gpr_wdata = out_data.gpr_wdata;
  assign out_csr_wen   = out_data.csr_wen;
  assign out_csr_waddr = out_data.csr_waddr;
  assign out_csr_wdata = out_data.csr_wdata;

  // bus side
  assign mem_arvalid = mem.arvalid;
  assign mem.arready = mem_arready;
  assign mem_araddr  = mem.araddr;
  assign mem_arsize  = mem.arsize;
  assign mem.rvalid  = mem_rvalid;
  assign mem_rready  = mem.rready;
  assign mem.rdata   = mem_rdata;
  assign mem_awvalid = mem.awvalid;
  assign mem.awready = mem_awready;
  assign mem_awaddr  = mem.awaddr;
  assign mem_awsize  = mem.awsize;
  assign mem_wvalid  = mem.wvalid;
  assign mem.wready  = mem_wready;
  assign mem_wdata   = mem.wdata;
  assign mem_wstrb   = mem.wstrb;
  assign mem.bvalid  = mem_bvalid;
  assign mem_bready  = mem.bready;

endmodule
